// File: source/issue_pkg.sv
`default_nettype none

package issue_pkg;

    localparam int NUM_THREADS = 4;
    localparam int NUM_REGS    = 32;

    typedef logic [4:0] reg_idx_t;

    typedef enum logic [1:0] {
        EX_ALU = 2'd0,
        EX_LSU = 2'd1,
        EX_CSR = 2'd2
    } ex_type_t;

    localparam logic [6:0] OPC_ALU_R  = 7'b0110011;
    localparam logic [6:0] OPC_ALU_I  = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // opcode field lines up in both views, so either one can be used to pick the format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_word_u;

    typedef struct packed {
        logic [NUM_THREADS-1:0] tmask;
        logic [31:0]            pc;
        ex_type_t               ex_type;
        logic [2:0]             op_type;
        logic                   wb;
        reg_idx_t               rd;
        reg_idx_t               rs1;
        reg_idx_t               rs2;
        logic [11:0]            imm;
        logic                   use_imm;  // rs2 is not read when set
    } decoded_instr_t;

endpackage

`default_nettype wire

// File: source/instr_decoder.sv
`default_nettype none

module instr_decoder
    import issue_pkg::*;
#(
    parameter int NUM_WARPS = 4,
    localparam int WID_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  wire logic                   fetch_valid,
    output logic                        fetch_ready,
    input  wire logic [WID_W-1:0]       fetch_wid,
    input  wire instr_word_u            fetch_word,
    input  wire logic [31:0]            fetch_pc,
    input  wire logic [NUM_THREADS-1:0] fetch_tmask,

    output logic                        dec_valid,
    input  wire logic                   enq_ready,
    output logic [WID_W-1:0]            dec_wid,
    output decoded_instr_t              dec_instr
);
    logic [6:0] opcode;

    assign opcode      = fetch_word.r.opcode;
    assign dec_valid   = fetch_valid;
    assign fetch_ready = enq_ready;  // the buffer decides acceptance
    assign dec_wid     = fetch_wid;

    always_comb begin
        dec_instr         = '0;
        dec_instr.tmask   = fetch_tmask;
        dec_instr.pc      = fetch_pc;
        dec_instr.op_type = fetch_word.r.funct3;

        case (opcode)
            OPC_ALU_R: begin
                dec_instr.ex_type = EX_ALU;
                dec_instr.wb      = 1'b1;
                dec_instr.rd      = fetch_word.r.rd;
                dec_instr.rs1     = fetch_word.r.rs1;
                dec_instr.rs2     = fetch_word.r.rs2;
            end
            OPC_ALU_I: begin
                dec_instr.ex_type = EX_ALU;
                dec_instr.wb      = 1'b1;
                dec_instr.rd      = fetch_word.i.rd;
                dec_instr.rs1     = fetch_word.i.rs1;
                dec_instr.imm     = fetch_word.i.imm;
                dec_instr.use_imm = 1'b1;
            end
            OPC_LOAD: begin
                dec_instr.ex_type = EX_LSU;
                dec_instr.wb      = 1'b1;
                dec_instr.rd      = fetch_word.i.rd;
                dec_instr.rs1     = fetch_word.i.rs1;
                dec_instr.imm     = fetch_word.i.imm;
                dec_instr.use_imm = 1'b1;
            end
            OPC_STORE: begin
                dec_instr.ex_type = EX_LSU;  // offset bits are dropped, only the registers matter here
                dec_instr.rs1     = fetch_word.r.rs1;
                dec_instr.rs2     = fetch_word.r.rs2;
            end
            OPC_SYSTEM: begin
                dec_instr.ex_type = EX_CSR;
                dec_instr.wb      = 1'b1;
                dec_instr.rd      = fetch_word.i.rd;
                dec_instr.rs1     = fetch_word.i.rs1;
                dec_instr.imm     = fetch_word.i.imm;  // csr address
                dec_instr.use_imm = 1'b1;
            end
            default: begin
                // unknown opcodes become an alu no-op that writes nothing
                dec_instr.ex_type = EX_ALU;
                dec_instr.op_type = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/instr_buffer.sv
`default_nettype none

module instr_buffer
    import issue_pkg::*;
#(
    parameter int NUM_WARPS   = 4,
    parameter int QUEUE_DEPTH = 3,
    localparam int WID_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  wire logic             clk,
    input  wire logic             reset,

    input  wire logic             enq_valid,
    output logic                  enq_ready,
    input  wire logic [WID_W-1:0] enq_wid,
    input  wire decoded_instr_t   enq_instr,

    output logic                  deq_valid,
    input  wire logic             deq_ready,
    output logic [WID_W-1:0]      deq_wid,
    output decoded_instr_t        deq_instr
);
    localparam int PTR_W  = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W  = $clog2(QUEUE_DEPTH + 1);
    localparam int NWARPW = $clog2(NUM_WARPS + 1);

    logic                             enq_fire;
    logic                             deq_fire;
    logic [NUM_WARPS-1:0]             q_empty;
    logic [NUM_WARPS-1:0]             q_alm_empty;
    logic [NUM_WARPS-1:0]             q_full;
    logic [NUM_WARPS-1:0]             q_valid_n;
    decoded_instr_t [NUM_WARPS-1:0]   q_head_n;

    assign enq_fire  = enq_valid && enq_ready;
    assign deq_fire  = deq_valid && deq_ready;
    assign enq_ready = !q_full[enq_wid];

    // each queue holds every pending instruction of its warp, the one shown at the output included
    for (genvar i = 0; i < NUM_WARPS; i++) begin : g_queue
        decoded_instr_t   mem [QUEUE_DEPTH];
        logic [PTR_W-1:0] rd_ptr;
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr_inc;
        logic [PTR_W-1:0] wr_ptr_inc;
        logic [CNT_W-1:0] used;
        logic             empty;
        logic             alm_empty;  // one entry or none
        logic             full;
        logic             writing;
        logic             reading;
        logic             drained;

        assign writing    = enq_fire && (enq_wid == WID_W'(i));
        assign reading    = deq_fire && (deq_wid == WID_W'(i));
        assign rd_ptr_inc = (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        assign wr_ptr_inc = (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        assign drained    = reading ? alm_empty : empty;

        always_ff @(posedge clk) begin
            if (reset) begin
                rd_ptr    <= '0;
                wr_ptr    <= '0;
                used      <= '0;
                empty     <= 1'b1;
                alm_empty <= 1'b1;
                full      <= 1'b0;
            end else begin
                if (writing) begin
                    wr_ptr <= wr_ptr_inc;
                end
                if (reading) begin
                    rd_ptr <= rd_ptr_inc;
                end
                if (writing && !reading) begin
                    empty <= 1'b0;
                    if (used == CNT_W'(1)) begin
                        alm_empty <= 1'b0;
                    end
                    if (used == CNT_W'(QUEUE_DEPTH - 1)) begin
                        full <= 1'b1;
                    end
                end else if (reading && !writing) begin
                    full <= 1'b0;
                    if (used == CNT_W'(1)) begin
                        empty <= 1'b1;
                    end
                    if (used == CNT_W'(2)) begin
                        alm_empty <= 1'b1;
                    end
                end
                used <= used + CNT_W'(writing) - CNT_W'(reading);
            end
        end

        always_ff @(posedge clk) begin
            if (writing) begin
                mem[wr_ptr] <= enq_instr;
            end
        end

        assign q_empty[i]     = empty;
        assign q_alm_empty[i] = alm_empty;
        assign q_full[i]      = full;
        assign q_valid_n[i]   = !drained || writing;
        assign q_head_n[i]    = drained ? enq_instr : mem[reading ? rd_ptr_inc : rd_ptr];
    end

    logic [NWARPW-1:0]    num_warps;
    logic [NUM_WARPS-1:0] schedule_table;
    logic [NUM_WARPS-1:0] schedule_table_n;
    logic [NUM_WARPS-1:0] rr_cand;
    logic [WID_W-1:0]     rr_wid;
    logic                 rr_found;
    logic                 deq_valid_n;
    logic [WID_W-1:0]     deq_wid_n;
    decoded_instr_t       deq_instr_n;
    logic                 warp_added;
    logic                 warp_removed;

    // schedule table marks the warps after the last pick, wrap to the lowest when none is left
    always_comb begin
        rr_cand = q_valid_n & schedule_table;
        if (rr_cand == '0) begin
            rr_cand = q_valid_n;
        end
        rr_wid   = '0;
        rr_found = 1'b0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            if (rr_cand[w] && !rr_found) begin
                rr_wid   = WID_W'(w);
                rr_found = 1'b1;
            end
        end
    end

    always_comb begin
        deq_valid_n = deq_valid;  // a head that was not taken stays put
        deq_wid_n   = deq_wid;
        deq_instr_n = deq_instr;
        if (!deq_valid || deq_fire) begin
            if ((num_warps == '0)
             || (num_warps == NWARPW'(1) && deq_fire && q_alm_empty[deq_wid])) begin
                deq_valid_n = enq_fire;
                deq_wid_n   = enq_wid;
                deq_instr_n = enq_instr;
            end else if (num_warps == NWARPW'(1)) begin
                deq_valid_n = q_valid_n[deq_wid];
                deq_instr_n = q_head_n[deq_wid];
            end else begin
                deq_valid_n = rr_found;
                deq_wid_n   = rr_wid;
                deq_instr_n = q_head_n[rr_wid];
            end
        end
        for (int w = 0; w < NUM_WARPS; w++) begin
            schedule_table_n[w] = (w > int'(deq_wid_n));
        end
    end

    assign warp_added   = enq_fire && q_empty[enq_wid];
    assign warp_removed = deq_fire && q_alm_empty[deq_wid]
                       && !(enq_fire && enq_wid == deq_wid);

    always_ff @(posedge clk) begin
        if (reset) begin
            deq_valid      <= 1'b0;
            num_warps      <= '0;
            schedule_table <= '0;
        end else begin
            deq_valid <= deq_valid_n;
            if (!deq_valid || deq_fire) begin
                schedule_table <= schedule_table_n;
            end
            if (warp_added && !warp_removed) begin
                num_warps <= num_warps + NWARPW'(1);
            end else if (warp_removed && !warp_added) begin
                num_warps <= num_warps - NWARPW'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        deq_wid   <= deq_wid_n;
        deq_instr <= deq_instr_n;
    end

endmodule

`default_nettype wire

// File: source/scoreboard.sv
`default_nettype none

module scoreboard
    import issue_pkg::*;
#(
    parameter int NUM_WARPS = 4,
    localparam int WID_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  wire logic             clk,
    input  wire logic             reset,

    input  wire logic             issue_fire,
    input  wire logic [WID_W-1:0] issue_wid,
    input  wire reg_idx_t         issue_rd,
    input  wire logic             issue_wb,

    input  wire logic             wb_valid,
    input  wire logic [WID_W-1:0] wb_wid,
    input  wire reg_idx_t         wb_rd,

    output logic [NUM_WARPS-1:0][NUM_REGS-1:0] busy_regs
);
    logic mark;
    logic clear;

    // x0 never holds a pending write
    assign mark  = issue_fire && issue_wb && (issue_rd != '0);
    assign clear = wb_valid && (wb_rd != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_regs <= '0;
        end else begin
            if (clear) begin
                busy_regs[wb_wid][wb_rd] <= 1'b0;
            end
            if (mark) begin
                busy_regs[issue_wid][issue_rd] <= 1'b1;  // placed last so a new issue beats a writeback
            end
        end
    end

endmodule

`default_nettype wire

// File: source/issue_select.sv
`default_nettype none

module issue_select
    import issue_pkg::*;
#(
    parameter int NUM_WARPS = 4,
    localparam int WID_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  wire logic                          deq_valid,
    output logic                               deq_ready,
    input  wire logic [WID_W-1:0]              deq_wid,
    input  wire decoded_instr_t                deq_instr,

    input  wire logic [NUM_WARPS-1:0][NUM_REGS-1:0] busy_regs,

    output logic                               issue_valid,
    input  wire logic                          issue_ready,
    output logic [WID_W-1:0]                   issue_wid,
    output decoded_instr_t                     issue_instr,
    output logic                               issue_fire
);
    logic [NUM_REGS-1:0] warp_busy;
    logic                rs1_busy;
    logic                rs2_busy;
    logic                rd_busy;
    logic                hazard;

    assign warp_busy = busy_regs[deq_wid];
    assign rs1_busy  = warp_busy[deq_instr.rs1];
    assign rs2_busy  = !deq_instr.use_imm && warp_busy[deq_instr.rs2];  // register format and stores
    assign rd_busy   = deq_instr.wb && warp_busy[deq_instr.rd];
    assign hazard    = rs1_busy || rs2_busy || rd_busy;

    assign issue_valid = deq_valid && !hazard;
    assign deq_ready   = issue_ready && !hazard;
    assign issue_fire  = issue_valid && issue_ready;
    assign issue_wid   = deq_wid;
    assign issue_instr = deq_instr;

endmodule

`default_nettype wire

// File: source/instr_issue_unit.sv
`default_nettype none

module instr_issue_unit
    import issue_pkg::*;
#(
    parameter int NUM_WARPS   = 4,
    parameter int QUEUE_DEPTH = 3,
    localparam int WID_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  wire logic                   clk,
    input  wire logic                   reset,

    input  wire logic                   fetch_valid,
    output logic                        fetch_ready,
    input  wire logic [WID_W-1:0]       fetch_wid,
    input  wire instr_word_u            fetch_word,
    input  wire logic [31:0]            fetch_pc,
    input  wire logic [NUM_THREADS-1:0] fetch_tmask,

    input  wire logic                   wb_valid,
    input  wire logic [WID_W-1:0]       wb_wid,
    input  wire reg_idx_t               wb_rd,

    output logic                        issue_valid,
    input  wire logic                   issue_ready,
    output logic [WID_W-1:0]            issue_wid,
    output decoded_instr_t              issue_instr
);
    logic                                dec_valid;
    logic                                enq_ready;
    logic [WID_W-1:0]                    dec_wid;
    decoded_instr_t                      dec_instr;
    logic                                deq_valid;
    logic                                deq_ready;
    logic [WID_W-1:0]                    deq_wid;
    decoded_instr_t                      deq_instr;
    logic [NUM_WARPS-1:0][NUM_REGS-1:0]  busy_regs;
    logic                                issue_fire;

    instr_decoder #(
        .NUM_WARPS (NUM_WARPS)
    ) u_decoder (
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_wid   (fetch_wid),
        .fetch_word  (fetch_word),
        .fetch_pc    (fetch_pc),
        .fetch_tmask (fetch_tmask),
        .dec_valid   (dec_valid),
        .enq_ready   (enq_ready),
        .dec_wid     (dec_wid),
        .dec_instr   (dec_instr)
    );

    instr_buffer #(
        .NUM_WARPS   (NUM_WARPS),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_buffer (
        .clk       (clk),
        .reset     (reset),
        .enq_valid (dec_valid),
        .enq_ready (enq_ready),
        .enq_wid   (dec_wid),
        .enq_instr (dec_instr),
        .deq_valid (deq_valid),
        .deq_ready (deq_ready),
        .deq_wid   (deq_wid),
        .deq_instr (deq_instr)
    );

    scoreboard #(
        .NUM_WARPS (NUM_WARPS)
    ) u_scoreboard (
        .clk        (clk),
        .reset      (reset),
        .issue_fire (issue_fire),
        .issue_wid  (issue_wid),
        .issue_rd   (issue_instr.rd),
        .issue_wb   (issue_instr.wb),
        .wb_valid   (wb_valid),
        .wb_wid     (wb_wid),
        .wb_rd      (wb_rd),
        .busy_regs  (busy_regs)
    );

    issue_select #(
        .NUM_WARPS (NUM_WARPS)
    ) u_select (
        .deq_valid   (deq_valid),
        .deq_ready   (deq_ready),
        .deq_wid     (deq_wid),
        .deq_instr   (deq_instr),
        .busy_regs   (busy_regs),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_wid   (issue_wid),
        .issue_instr (issue_instr),
        .issue_fire  (issue_fire)
    );

endmodule

`default_nettype wire

// File: verification/tb_instr_issue_unit.sv
`default_nettype none

module tb_instr_issue_unit
    import issue_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_WARPS        = 4;
    localparam int QUEUE_DEPTH      = 3;
    localparam int WID_W            = $clog2(NUM_WARPS);
    localparam int CLK_PERIOD       = 100;
    localparam int RESET_CYCLES     = 4;
    localparam int NUM_TESTS        = 3;
    localparam int TEST_FETCHES     = 150;
    localparam int CYCLES_PER_INSTR = 40;  // hazard wait, late writeback and a stalled issue port
    localparam int WATCHDOG_CYCLES  = RESET_CYCLES + NUM_TESTS * TEST_FETCHES * CYCLES_PER_INSTR;

    typedef struct packed {
        logic [31:0]      due;
        logic [WID_W-1:0] wid;
        reg_idx_t         rd;
    } wb_req_t;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   fetch_valid;
    logic                   fetch_ready;
    logic [WID_W-1:0]       fetch_wid;
    instr_word_u            fetch_word;
    logic [31:0]            fetch_pc;
    logic [NUM_THREADS-1:0] fetch_tmask;
    logic                   wb_valid;
    logic [WID_W-1:0]       wb_wid;
    reg_idx_t               wb_rd;
    logic                   issue_valid;
    logic                   issue_ready;
    logic [WID_W-1:0]       issue_wid;
    decoded_instr_t         issue_instr;

    decoded_instr_t      exp_q [NUM_WARPS][$];  // pending instructions per warp in fetch order
    logic [NUM_REGS-1:0] shadow_busy [NUM_WARPS];
    int                  skips [NUM_WARPS];  // issues of other warps while this one had entries
    wb_req_t             wb_pend [$];
    int                  cycle;
    int                  errors;
    int                  issued;
    int                  fetched;
    bit                  fetching;
    int                  ready_pct;
    int                  fetch_pct;
    int                  wid_lo;
    int                  wid_hi;
    bit                  hold_pending;
    logic [WID_W-1:0]    hold_wid;
    decoded_instr_t      hold_instr;
    bit                  bypass_pending;
    logic [WID_W-1:0]    bypass_wid;

    always #(CLK_PERIOD / 2) clk = ~clk;

    instr_issue_unit #(
        .NUM_WARPS   (NUM_WARPS),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_dut (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_wid   (fetch_wid),
        .fetch_word  (fetch_word),
        .fetch_pc    (fetch_pc),
        .fetch_tmask (fetch_tmask),
        .wb_valid    (wb_valid),
        .wb_wid      (wb_wid),
        .wb_rd       (wb_rd),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_wid   (issue_wid),
        .issue_instr (issue_instr)
    );

    function automatic decoded_instr_t expected_decode(input logic [31:0] w,
                                                       input logic [31:0] pc,
                                                       input logic [NUM_THREADS-1:0] tmask);
        decoded_instr_t d;
        d         = '0;
        d.tmask   = tmask;
        d.pc      = pc;
        d.ex_type = EX_ALU;
        d.op_type = w[14:12];
        if (w[6:0] inside {OPC_ALU_R, OPC_ALU_I, OPC_LOAD, OPC_SYSTEM}) begin
            d.wb = 1'b1;  // everything known but a store writes rd
            d.rd = w[11:7];
        end
        if (w[6:0] inside {OPC_ALU_R, OPC_ALU_I, OPC_LOAD, OPC_STORE, OPC_SYSTEM}) begin
            d.rs1 = w[19:15];
        end else begin
            d.op_type = '0;
        end
        if (w[6:0] inside {OPC_ALU_R, OPC_STORE}) begin
            d.rs2 = w[24:20];
        end else if (w[6:0] inside {OPC_ALU_I, OPC_LOAD, OPC_SYSTEM}) begin
            d.imm     = w[31:20];
            d.use_imm = 1'b1;
        end
        if (w[6:0] inside {OPC_LOAD, OPC_STORE}) begin
            d.ex_type = EX_LSU;
        end
        if (w[6:0] == OPC_SYSTEM) begin
            d.ex_type = EX_CSR;
        end
        return d;
    endfunction

    function automatic bit head_blocked(input logic [WID_W-1:0] wid, input decoded_instr_t d);
        return shadow_busy[wid][d.rs1]
            || (!d.use_imm && shadow_busy[wid][d.rs2])
            || (d.wb && shadow_busy[wid][d.rd]);
    endfunction

    function automatic instr_word_u random_word();
        logic [31:0] w;
        w = $urandom;
        case ($urandom_range(0, 5))
            0: w[6:0] = OPC_ALU_R;
            1: w[6:0] = OPC_ALU_I;
            2: w[6:0] = OPC_LOAD;
            3: w[6:0] = OPC_STORE;
            4: w[6:0] = OPC_SYSTEM;
            default: w[6:0] = 7'($urandom);
        endcase
        w[11:7]  = 5'($urandom_range(0, 7));  // few registers so hazards show up often
        w[19:15] = 5'($urandom_range(0, 7));
        w[24:20] = 5'($urandom_range(0, 7));
        return w;
    endfunction

    function automatic bit model_idle();
        bit idle;
        idle = 1'b1;
        for (int w = 0; w < NUM_WARPS; w++) begin
            idle = idle && (exp_q[w].size() == 0) && (shadow_busy[w] == '0);
        end
        return idle;
    endfunction

    task automatic check_issue(input logic [WID_W-1:0] got_wid, input decoded_instr_t got,
                               input logic [WID_W-1:0] exp_wid, input decoded_instr_t exp,
                               input string what);
        if (got_wid !== exp_wid || got !== exp) begin
            $display("Mismatch at %0t: %s, warp %0d instr %h, expected warp %0d instr %h",
                     $time, what, got_wid, got, exp_wid, exp);
            errors++;
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic drive_inputs();
        bit found;
        found = 1'b0;
        fetch_valid <= fetching && (fetched < TEST_FETCHES) && ($urandom_range(0, 99) < fetch_pct);
        fetch_wid   <= WID_W'($urandom_range(wid_lo, wid_hi));
        fetch_word  <= random_word();
        fetch_pc    <= $urandom;
        fetch_tmask <= NUM_THREADS'($urandom);
        issue_ready <= $urandom_range(0, 99) < ready_pct;
        wb_valid    <= 1'b0;
        for (int i = 0; i < wb_pend.size() && !found; i++) begin
            if (wb_pend[i].due <= 32'(cycle)) begin
                found = 1'b1;
                wb_valid <= 1'b1;
                wb_wid   <= wb_pend[i].wid;
                wb_rd    <= wb_pend[i].rd;
                wb_pend.delete(i);
            end
        end
    endtask

    // outputs are sampled on the falling edge, the model then steps past the next rising edge
    task automatic step();
        bit             fire;
        bit             all_empty;
        decoded_instr_t head;
        wb_req_t        req;
        @(negedge clk);
        cycle++;
        check_level(fetch_ready, exp_q[fetch_wid].size() != QUEUE_DEPTH, "fetch_ready");
        if (hold_pending) begin
            check_level(issue_valid, 1'b1, "issue_valid of a held head");
            check_issue(issue_wid, issue_instr, hold_wid, hold_instr, "held head");
        end
        if (bypass_pending && !head_blocked(bypass_wid, exp_q[bypass_wid][0])) begin
            check_level(issue_valid, 1'b1, "issue_valid one cycle after a fetch into empty warps");
            check_issue(issue_wid, issue_instr, bypass_wid, exp_q[bypass_wid][0], "bypassed fetch");
        end
        fire = issue_valid && issue_ready;
        if (issue_valid && exp_q[issue_wid].size() == 0) begin
            $display("Error at %0t: warp %0d issued with no instruction pending", $time, issue_wid);
            errors++;
            fire = 1'b0;
        end else if (issue_valid) begin
            check_issue(issue_wid, issue_instr, issue_wid, exp_q[issue_wid][0], "issued instr");
            check_level(head_blocked(issue_wid, exp_q[issue_wid][0]), 1'b0, "hazard on issue");
        end
        hold_pending = issue_valid && !issue_ready;
        hold_wid     = issue_wid;
        hold_instr   = issue_instr;

        if (wb_valid) begin
            shadow_busy[wb_wid][wb_rd] = 1'b0;  // cleared before the mark so a new issue wins
        end
        if (fire) begin
            head = exp_q[issue_wid].pop_front();
            issued++;
            skips[issue_wid] = 0;
            if (head.wb && head.rd != '0) begin
                shadow_busy[issue_wid][head.rd] = 1'b1;
                req.due = 32'(cycle) + $urandom_range(1, 4);
                req.wid = issue_wid;
                req.rd  = head.rd;
                wb_pend.push_back(req);
            end
        end
        all_empty = 1'b1;
        for (int w = 0; w < NUM_WARPS; w++) begin
            all_empty = all_empty && (exp_q[w].size() == 0);
        end
        bypass_pending = fetch_valid && fetch_ready && all_empty;
        bypass_wid     = fetch_wid;
        if (fetch_valid && fetch_ready) begin
            exp_q[fetch_wid].push_back(expected_decode(fetch_word, fetch_pc, fetch_tmask));
            fetched++;
        end
        for (int w = 0; w < NUM_WARPS; w++) begin
            if (fire && WID_W'(w) != issue_wid && exp_q[w].size() != 0) begin
                skips[w]++;
            end
            if (skips[w] > NUM_WARPS) begin
                $display("Error at %0t: warp %0d was passed over by %0d issues of other warps",
                         $time, w, skips[w]);
                errors++;
                skips[w] = 0;
            end
            if (exp_q[w].size() == 0) begin
                skips[w] = 0;
            end
        end
        @(posedge clk);
        drive_inputs();
    endtask

    task automatic run_test(input string name, input int r_pct, input int f_pct,
                            input int lo, input int hi);
        int start_errors;
        int start_issued;
        start_errors = errors;
        start_issued = issued;
        ready_pct    = r_pct;
        fetch_pct    = f_pct;
        wid_lo       = lo;
        wid_hi       = hi;
        fetched      = 0;
        fetching     = 1'b1;
        while (fetched < TEST_FETCHES) begin
            step();
        end
        fetching  = 1'b0;
        ready_pct = 100;  // drain the queues and the scoreboard
        while (!model_idle()) begin
            step();
        end
        $display("%s: %0d issued, %0d errors", name, issued - start_issued,
                 errors - start_errors);
    endtask

    initial begin
        void'($urandom(32'h55b6c978));
        reset          = 1'b1;
        fetch_valid    = 1'b0;
        fetch_wid      = '0;
        fetch_word     = '0;
        fetch_pc       = '0;
        fetch_tmask    = '0;
        wb_valid       = 1'b0;
        wb_wid         = '0;
        wb_rd          = '0;
        issue_ready    = 1'b0;
        cycle          = 0;
        errors         = 0;
        issued         = 0;
        fetching       = 1'b0;
        hold_pending   = 1'b0;
        bypass_pending = 1'b0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            shadow_busy[w] = '0;
            skips[w]       = 0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        run_test("mixed warps, random issue_ready", 70, 60, 0, NUM_WARPS - 1);
        run_test("round robin, issue_ready high", 100, 90, 0, NUM_WARPS - 1);
        run_test("single warp back-pressure", 25, 90, 2, 2);

        $display("%0d tests, %0d instructions issued, %0d errors", NUM_TESTS, issued, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: still running after %0d cycles, an instruction was lost or stuck",
                 WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: instr_issue_unit.f
source/issue_pkg.sv
source/instr_decoder.sv
source/instr_buffer.sv
source/scoreboard.sv
source/issue_select.sv
source/instr_issue_unit.sv
verification/tb_instr_issue_unit.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary -j 0 -Wno-fatal
TOP      := tb_instr_issue_unit
FILELIST := instr_issue_unit.f

SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir
